// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_dispatch -o tb_dispatch
	./obj_dir/tb_dispatch

clean:
	rm -rf obj_dir

// ==== bench/tb_dispatch.sv ====
`include "dispatch_macros.svh"

module tb_dispatch
    import dispatch_pkg::*;
();

    localparam int CYCLES     = 3000;
    localparam int MAX_CYCLES = 2 * CYCLES + 100;
    localparam int BS_IDLE    = 0;
    localparam int BS_SPEC    = 1;
    localparam int BS_JUMP    = 2;

    logic                      CLK;
    logic                      nRST;
    fetch_t                    fetch;
    wb_t                       wb;
    logic [`NUM_FU-1:0]        fu_ex;
    logic                      branch_resolved;
    logic                      branch_miss;
    logic                      freeze;
    logic                      jump;
    fust_entry_t [`NUM_FU-1:0] fust;
    logic                      halt;

    integer seed;
    int     cycles;

    // reference model of the register tables, entries and branch state
    logic [`SREGS-1:0]             s_busy;
    logic [`SREGS-1:0][`TAG_W-1:0] s_tag;
    logic [`SREGS-1:0]             s_spec;
    logic [`MREGS-1:0]             m_busy;
    logic [`MREGS-1:0][`TAG_W-1:0] m_tag;
    logic [`MREGS-1:0]             m_spec;
    fust_entry_t [`NUM_FU-1:0]     ent;
    int                            bstate;
    logic                          halt_exp;
    logic                          freeze_exp;

    dispatch_top dut_i (
        .CLK(CLK), .nRST(nRST),
        .fetch(fetch), .wb(wb), .fu_ex(fu_ex),
        .branch_resolved(branch_resolved), .branch_miss(branch_miss),
        .freeze(freeze), .jump(jump), .fust(fust), .halt(halt)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("TESTS FAILED");
            $fatal(1, "timeout, run still going after %0d cycles", MAX_CYCLES);
        end
    end

    task automatic compare(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("FAIL time=%0t %s expected %h got %h", $time, name, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // a same-cycle writeback makes the source ready
    function automatic logic [`TAG_W-1:0] s_src_tag(input logic [4:0] idx);
        if (wb.s_en && wb.s_rd == idx)
            return '0;
        return s_tag[idx];
    endfunction

    function automatic logic [`TAG_W-1:0] m_src_tag(input logic [3:0] idx);
        if (wb.m_en && wb.m_rd == idx)
            return '0;
        return m_tag[idx];
    endfunction

    function automatic logic wb_hits(input logic mat, input logic [`TAG_W-1:0] t);
        if (t == '0)
            return 1'b0;
        if (mat)
            return wb.m_en && t == wb.m_tag;
        return wb.s_en && t == wb.s_tag;
    endfunction

    function automatic logic [`WORD_W-1:0] random_instr();
        logic [`WORD_W-1:0] w;
        int                 pick;
        w    = $random(seed);
        pick = $unsigned($random(seed)) % 16;
        case (pick)
            0, 1, 2: w[6:0] = OP_ALU;
            3, 4:    w[6:0] = OP_ALUI;
            5, 6:    w[6:0] = OP_LOAD;
            7:       w[6:0] = OP_STORE;
            8, 9:    w[6:0] = OP_BRANCH;
            10:      w[6:0] = OP_JAL;
            11:      w[6:0] = OP_MLOAD;
            12:      w[6:0] = OP_MSTORE;
            13, 14:  w[6:0] = OP_GEMM;
            default: begin
                if (w[31])
                    w[6:0] = OP_HALT;
                else
                    w[6:0] = 7'b1011011;
            end
        endcase
        // few registers so that hazards and tag hits show up often
        w[19:18] = 2'b00;
        w[24:23] = 2'b00;
        if (pick >= 11 && pick <= 14)
            w[31:30] = 2'b00;
        else
            w[11:10] = 2'b00;
        return w;
    endfunction

    task automatic check_state();
        compare("halt", 64'(halt_exp), 64'(halt));
        for (int i = 0; i < `NUM_FU; i++)
            compare($sformatf("fust[%0d]", i), 64'(ent[i]), 64'(fust[i]));
    endtask

    task automatic predict_cycle();
        logic [`WORD_W-1:0]        w;
        logic [4:0]                rd;
        logic [4:0]                rs1;
        logic [4:0]                rs2;
        logic [3:0]                md;
        logic [3:0]                ms1;
        logic [3:0]                ms2;
        logic [3:0]                ms3;
        fu_t                       fu;
        logic                      s_wr;
        logic                      m_wr;
        logic                      is_br;
        logic                      is_j;
        logic                      hlt;
        logic                      hz;
        logic                      go;
        logic                      nspec;
        logic [`TAG_W-1:0]         s_new;
        logic [`TAG_W-1:0]         m_new;
        fust_entry_t               e;
        fust_entry_t [`NUM_FU-1:0] nxt;

        w     = fetch.instr;
        rd    = w[11:7];
        rs1   = w[19:15];
        rs2   = w[24:20];
        md    = w[31:28];
        ms1   = w[27:24];
        ms2   = w[23:20];
        ms3   = w[19:16];
        fu    = FU_NONE;
        s_wr  = 1'b0;
        m_wr  = 1'b0;
        is_br = 1'b0;
        is_j  = 1'b0;
        hlt   = 1'b0;
        nspec = (bstate == BS_SPEC) && !branch_resolved;

        e      = '0;
        e.busy = 1'b1;
        e.spec = nspec;
        case (w[6:0])
            OP_ALU: begin
                fu   = FU_ALU;
                s_wr = 1'b1;
                e.op = {w[30], w[14:12]};
            end
            OP_ALUI, OP_LOAD: begin
                // only the alu form has bit 4 set
                fu = FU_LDST;
                if (w[4])
                    fu = FU_ALU;
                s_wr  = 1'b1;
                e.op  = {1'b0, w[14:12]};
                e.imm = {{20{w[31]}}, w[31:20]};
            end
            OP_STORE: begin
                fu    = FU_LDST;
                e.op  = {1'b1, w[14:12]};
                e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OP_BRANCH: begin
                fu    = FU_BRANCH;
                is_br = 1'b1;
                e.op  = {1'b0, w[14:12]};
                e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OP_JAL: begin
                fu    = FU_BRANCH;
                is_j  = 1'b1;
                s_wr  = 1'b1;
                e.op  = 4'b1000;
                e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OP_MLOAD, OP_MSTORE: begin
                fu    = FU_MLS;
                m_wr  = (w[6:0] == OP_MLOAD);
                e.op  = m_wr ? 4'b0000 : 4'b1000;
                e.imm = {{24{w[27]}}, w[27:20]};
            end
            OP_GEMM: begin
                fu    = FU_GEMM;
                m_wr  = 1'b1;
                e.op  = {1'b0, w[9:7]};
                e.imm = {28'd0, ms3};
            end
            OP_HALT: hlt = 1'b1;
            default: ;
        endcase

        // operand view follows the unit
        case (fu)
            FU_MLS: begin
                e.rd  = {1'b0, md};
                e.rs1 = rs1;
                e.t1  = s_src_tag(rs1);
                if (!m_wr) begin
                    e.rs2 = {1'b0, md};
                    e.t2  = m_src_tag(md);
                end
            end
            FU_GEMM: begin
                e.rd  = {1'b0, md};
                e.rs1 = {1'b0, ms1};
                e.rs2 = {1'b0, ms2};
                e.t1  = m_src_tag(ms1);
                e.t2  = m_src_tag(ms2);
                e.t3  = m_src_tag(ms3);
            end
            default: begin
                e.rd  = rd;
                e.rs1 = rs1;
                e.rs2 = rs2;
                e.t1  = s_src_tag(rs1);
                e.t2  = s_src_tag(rs2);
                if (fu == FU_BRANCH)
                    e.imm = fetch.pc + e.imm;
            end
        endcase

        hz = (s_wr && s_busy[rd]) || (m_wr && m_busy[md]) ||
             ((is_br || is_j) && bstate != BS_IDLE);
        if (fu != FU_NONE && ent[fu].busy)
            hz = 1'b1;
        go = fetch.valid && !hz && !branch_miss;
        compare("freeze", 64'(fetch.valid && hz), 64'(freeze));
        compare("jump", 64'(bstate == BS_JUMP || (go && is_j)), 64'(jump));

        s_new = 2'd1;
        if (fu == FU_LDST)
            s_new = 2'd3;
        else if (fu == FU_BRANCH)
            s_new = 2'd2;
        m_new = (fu == FU_MLS) ? 2'd2 : 2'd1;

        nxt = ent;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (ent[i].busy) begin
                // gemm sources are all matrix and mls has only its store data
                if (wb_hits(i == int'(FU_GEMM), ent[i].t1))
                    nxt[i].t1 = '0;
                if (wb_hits(i == int'(FU_GEMM) || i == int'(FU_MLS), ent[i].t2))
                    nxt[i].t2 = '0;
                if (wb_hits(1'b1, ent[i].t3))
                    nxt[i].t3 = '0;
            end
            if (fu_ex[i])
                nxt[i].busy = 1'b0;
            if (branch_miss && ent[i].busy && ent[i].spec) begin
                nxt[i].busy = 1'b0;
                nxt[i].spec = 1'b0;
            end
            if (go && fu != FU_NONE && int'(fu) == i)
                nxt[i] = e;
        end
        ent = nxt;

        for (int i = 0; i < `SREGS; i++)
            if (branch_miss && s_spec[i])
                s_tag[i] = '0;
        for (int i = 0; i < `MREGS; i++)
            if (branch_miss && m_spec[i])
                m_tag[i] = '0;
        if (branch_miss) begin
            s_busy = s_busy & ~s_spec;
            m_busy = m_busy & ~m_spec;
        end
        if (branch_miss || branch_resolved) begin
            s_spec = '0;
            m_spec = '0;
        end
        if (wb.s_en) begin
            s_busy[wb.s_rd] = 1'b0;
            s_tag[wb.s_rd]  = '0;
            s_spec[wb.s_rd] = 1'b0;
        end
        if (wb.m_en) begin
            m_busy[wb.m_rd] = 1'b0;
            m_tag[wb.m_rd]  = '0;
            m_spec[wb.m_rd] = 1'b0;
        end
        if (go && s_wr) begin
            s_busy[rd] = 1'b1;
            s_tag[rd]  = s_new;
            s_spec[rd] = nspec;
        end
        if (go && m_wr) begin
            m_busy[md] = 1'b1;
            m_tag[md]  = m_new;
            m_spec[md] = nspec;
        end

        if (bstate == BS_IDLE) begin
            if (go && is_j)
                bstate = BS_JUMP;
            else if (go && is_br)
                bstate = BS_SPEC;
        end else if (branch_resolved || branch_miss) begin
            bstate = BS_IDLE;
        end
        if (go && hlt)
            halt_exp = 1'b1;
        freeze_exp = fetch.valid && hz;
    endtask

    task automatic drive_inputs();
        fetch_t f;
        wb_t    w;
        int     start;
        int     r;
        f = fetch;
        // fetch holds the same word while frozen
        if (!freeze_exp) begin
            f.valid = ($random(seed) & 7) != 0;
            f.instr = random_instr();
            f.pc    = $random(seed) & 32'hffff_fffc;
        end
        // write back only registers that have a pending producer
        w     = '0;
        start = $unsigned($random(seed)) % `SREGS;
        if ($random(seed) & 1) begin
            for (int k = 0; k < `SREGS; k++) begin
                r = (start + k) % `SREGS;
                if (!w.s_en && s_busy[r]) begin
                    w.s_en  = 1'b1;
                    w.s_rd  = 5'(r);
                    w.s_tag = s_tag[r];
                end
            end
        end
        start = $unsigned($random(seed)) % `MREGS;
        if ($random(seed) & 1) begin
            for (int k = 0; k < `MREGS; k++) begin
                r = (start + k) % `MREGS;
                if (!w.m_en && m_busy[r]) begin
                    w.m_en  = 1'b1;
                    w.m_rd  = 4'(r);
                    w.m_tag = m_tag[r];
                end
            end
        end
        r = $unsigned($random(seed)) % 16;
        fetch           <= f;
        wb              <= w;
        fu_ex           <= `NUM_FU'($random(seed) & $random(seed));
        branch_resolved <= (bstate != BS_IDLE) && r < 2;
        branch_miss     <= (bstate != BS_IDLE) && r == 2;
    endtask

    initial begin
        seed            = 89;
        cycles          = 0;
        CLK             = 1'b0;
        nRST            = 1'b0;
        fetch           = '0;
        wb              = '0;
        fu_ex           = '0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        s_busy          = '0;
        s_tag           = '0;
        s_spec          = '0;
        m_busy          = '0;
        m_tag           = '0;
        m_spec          = '0;
        ent             = '0;
        bstate          = BS_IDLE;
        halt_exp        = 1'b0;
        freeze_exp      = 1'b0;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        // outputs settle by the falling edge while inputs change on the rising one
        repeat (CYCLES) begin
            @(negedge CLK);
            check_state();
            predict_cycle();
            @(posedge CLK);
            drive_inputs();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/dispatch_pkg.sv
verilog/instr_decoder.sv
verilog/reg_status_table.sv
verilog/branch_state.sv
verilog/dispatch_stage.sv
verilog/fu_status_table.sv
verilog/dispatch_top.sv
bench/tb_dispatch.sv

// ==== verilog/branch_state.sv ====
module branch_state (
    input  logic CLK,
    input  logic nRST,
    input  logic take_branch,
    input  logic take_jump,
    input  logic branch_resolved,
    input  logic branch_miss,
    output logic spec,
    output logic jump,
    output logic busy
);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] SPEC = 2'd1;
    localparam logic [1:0] JUMP = 2'd2;

    logic [1:0] state;
    logic [1:0] next_state;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            state <= IDLE;
        else
            state <= next_state;
    end

    // only one control transfer outstanding at a time
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (take_jump)
                    next_state = JUMP;
                else if (take_branch)
                    next_state = SPEC;
            end
            default: begin
                if (branch_resolved || branch_miss)
                    next_state = IDLE;
            end
        endcase
    end

    assign spec = (state == SPEC);
    assign jump = (state == JUMP);
    assign busy = (state != IDLE);

    a_one_transfer: assert property (@(posedge CLK) disable iff (!nRST)
        !(take_branch && take_jump))
        else $error("branch and jump taken in the same cycle");

endmodule

// ==== verilog/dispatch_macros.svh ====
`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// instruction and immediate widths
`define WORD_W 32
`define IMM_W 32

// architectural register counts
`define SREGS 32
`define MREGS 16

// producer tag where 0 means ready
`define TAG_W 2

// one status entry per unit
`define NUM_FU 5

`endif

// ==== verilog/dispatch_pkg.sv ====
`include "dispatch_macros.svh"

package dispatch_pkg;

    // entry index follows the enum value
    typedef enum logic [2:0] {
        FU_ALU    = 3'd0,
        FU_LDST   = 3'd1,
        FU_BRANCH = 3'd2,
        FU_MLS    = 3'd3,
        FU_GEMM   = 3'd4,
        FU_NONE   = 3'd7
    } fu_t;

    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_MLOAD  = 7'b0000111,
        OP_MSTORE = 7'b0100111,
        OP_GEMM   = 7'b1110111,
        OP_HALT   = 7'b1111111
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } scalar_fmt_t;

    // matrix load/store also reads the scalar rs1 field as base
    typedef struct packed {
        logic [3:0] md;
        logic [3:0] ms1;
        logic [3:0] ms2;
        logic [3:0] ms3;
        logic [8:0] low;
        logic [6:0] opcode;
    } matrix_fmt_t;

    typedef union packed {
        scalar_fmt_t scalar;
        matrix_fmt_t matrix;
    } instr_u;

    typedef struct packed {
        fu_t              fu;
        logic             s_write;
        logic             m_write;
        logic [`IMM_W-1:0] imm;
        logic [3:0]       alu_op;
        logic             is_branch;
        logic             is_jump;
        logic             halt;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        instr_u             instr;
        logic [`WORD_W-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic                       s_en;
        logic [$clog2(`SREGS)-1:0] s_rd;
        logic [`TAG_W-1:0]          s_tag;
        logic                       m_en;
        logic [$clog2(`MREGS)-1:0] m_rd;
        logic [`TAG_W-1:0]          m_tag;
    } wb_t;

    typedef struct packed {
        logic                       busy;
        logic                       spec;
        logic [3:0]                 op;
        logic [$clog2(`SREGS)-1:0] rd;
        logic [$clog2(`SREGS)-1:0] rs1;
        logic [$clog2(`SREGS)-1:0] rs2;
        logic [`TAG_W-1:0]          t1;
        logic [`TAG_W-1:0]          t2;
        logic [`TAG_W-1:0]          t3;
        logic [`IMM_W-1:0]          imm;
    } fust_entry_t;

    typedef struct packed {
        logic        en;
        fu_t         fu;
        fust_entry_t entry;
    } issue_t;

endpackage

// ==== verilog/dispatch_stage.sv ====
`include "dispatch_macros.svh"

module dispatch_stage
    import dispatch_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  fetch_t             fetch,
    input  wb_t                wb,
    input  logic               branch_resolved,
    input  logic               branch_miss,
    input  logic [`NUM_FU-1:0] fu_busy,
    output issue_t             issue,
    output logic               freeze,
    output logic               jump,
    output logic               halt
);

    localparam int SIDX_W = $clog2(`SREGS);
    localparam int MIDX_W = $clog2(`MREGS);

    // scalar producer tags followed by matrix ones
    localparam logic [`TAG_W-1:0] TAG_ALU   = 2'd1;
    localparam logic [`TAG_W-1:0] TAG_JUMP  = 2'd2;
    localparam logic [`TAG_W-1:0] TAG_LOAD  = 2'd3;
    localparam logic [`TAG_W-1:0] TAG_GEMM  = 2'd1;
    localparam logic [`TAG_W-1:0] TAG_MLOAD = 2'd2;

    ctrl_t       ctrl;
    scalar_fmt_t sf;
    matrix_fmt_t mf;
    fust_entry_t entry;

    logic [`SREGS-1:0]             s_busy;
    logic [`SREGS-1:0][`TAG_W-1:0] s_tag;
    logic [`MREGS-1:0]             m_busy;
    logic [`MREGS-1:0][`TAG_W-1:0] m_tag;

    logic br_spec, br_jump, br_busy;
    logic hazard, go, take_branch, take_jump, new_spec;
    logic [`TAG_W-1:0] s_di_tag, m_di_tag;
    logic [`TAG_W-1:0] st1, st2, mt1, mt2, mt3, mt_md;

    instr_decoder dec_i (.instr(fetch.instr), .ctrl(ctrl));

    assign sf = fetch.instr.scalar;
    assign mf = fetch.instr.matrix;

    always_comb begin
        hazard = 1'b0;
        if (ctrl.fu != FU_NONE && fu_busy[ctrl.fu])
            hazard = 1'b1;
        // WAW on either register file
        if (ctrl.s_write && s_busy[sf.rd])
            hazard = 1'b1;
        if (ctrl.m_write && m_busy[mf.md])
            hazard = 1'b1;
        if ((ctrl.is_branch || ctrl.is_jump) && br_busy)
            hazard = 1'b1;
    end

    assign freeze      = fetch.valid && hazard;
    assign go          = fetch.valid && !hazard && !branch_miss;
    assign take_branch = go && ctrl.is_branch;
    assign take_jump   = go && ctrl.is_jump;
    assign jump        = br_jump || take_jump;
    assign new_spec    = br_spec && !branch_resolved;

    // a result written back this cycle counts as ready
    assign st1   = (wb.s_en && wb.s_rd == sf.rs1) ? '0 : s_tag[sf.rs1];
    assign st2   = (wb.s_en && wb.s_rd == sf.rs2) ? '0 : s_tag[sf.rs2];
    assign mt1   = (wb.m_en && wb.m_rd == mf.ms1) ? '0 : m_tag[mf.ms1];
    assign mt2   = (wb.m_en && wb.m_rd == mf.ms2) ? '0 : m_tag[mf.ms2];
    assign mt3   = (wb.m_en && wb.m_rd == mf.ms3) ? '0 : m_tag[mf.ms3];
    assign mt_md = (wb.m_en && wb.m_rd == mf.md) ? '0 : m_tag[mf.md];

    always_comb begin
        entry      = '0;
        entry.busy = 1'b1;
        entry.spec = new_spec;
        entry.op   = ctrl.alu_op;
        entry.imm  = ctrl.imm;
        case (ctrl.fu)
            FU_MLS: begin
                entry.rd  = SIDX_W'(mf.md);
                entry.rs1 = sf.rs1;
                entry.t1  = st1;
                // store reads md as its data source
                if (!ctrl.m_write) begin
                    entry.rs2 = SIDX_W'(mf.md);
                    entry.t2  = mt_md;
                end
            end
            FU_GEMM: begin
                entry.rd  = SIDX_W'(mf.md);
                entry.rs1 = SIDX_W'(mf.ms1);
                entry.rs2 = SIDX_W'(mf.ms2);
                entry.t1  = mt1;
                entry.t2  = mt2;
                entry.t3  = mt3;
            end
            default: begin
                entry.rd  = sf.rd;
                entry.rs1 = sf.rs1;
                entry.rs2 = sf.rs2;
                entry.t1  = st1;
                entry.t2  = st2;
                // branch unit gets the target address
                if (ctrl.fu == FU_BRANCH)
                    entry.imm = fetch.pc + ctrl.imm;
            end
        endcase
    end

    assign issue.en    = go && (ctrl.fu != FU_NONE);
    assign issue.fu    = ctrl.fu;
    assign issue.entry = entry;

    assign s_di_tag = (ctrl.fu == FU_LDST) ? TAG_LOAD :
                      (ctrl.fu == FU_BRANCH) ? TAG_JUMP : TAG_ALU;
    assign m_di_tag = (ctrl.fu == FU_MLS) ? TAG_MLOAD : TAG_GEMM;

    reg_status_table #(.REGS(`SREGS), .IDX_W(SIDX_W)) srst (
        .CLK(CLK), .nRST(nRST),
        .di_en(go && ctrl.s_write), .di_sel(sf.rd), .di_tag(s_di_tag), .di_spec(new_spec),
        .wb_en(wb.s_en), .wb_sel(wb.s_rd),
        .flush(branch_miss), .resolved(branch_resolved),
        .busy(s_busy), .tag(s_tag)
    );

    reg_status_table #(.REGS(`MREGS), .IDX_W(MIDX_W)) mrst (
        .CLK(CLK), .nRST(nRST),
        .di_en(go && ctrl.m_write), .di_sel(mf.md), .di_tag(m_di_tag), .di_spec(new_spec),
        .wb_en(wb.m_en), .wb_sel(wb.m_rd),
        .flush(branch_miss), .resolved(branch_resolved),
        .busy(m_busy), .tag(m_tag)
    );

    branch_state bs_i (
        .CLK(CLK), .nRST(nRST),
        .take_branch(take_branch), .take_jump(take_jump),
        .branch_resolved(branch_resolved), .branch_miss(branch_miss),
        .spec(br_spec), .jump(br_jump), .busy(br_busy)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            halt <= 1'b0;
        else if (go && ctrl.halt)
            halt <= 1'b1;
    end

endmodule

// ==== verilog/dispatch_top.sv ====
`include "dispatch_macros.svh"

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    input  fetch_t                    fetch,
    input  wb_t                       wb,
    input  logic [`NUM_FU-1:0]        fu_ex,
    input  logic                      branch_resolved,
    input  logic                      branch_miss,
    output logic                      freeze,
    output logic                      jump,
    output fust_entry_t [`NUM_FU-1:0] fust,
    output logic                      halt
);

    issue_t             issue;
    logic [`NUM_FU-1:0] fu_busy;

    dispatch_stage stage_i (
        .CLK(CLK), .nRST(nRST),
        .fetch(fetch), .wb(wb),
        .branch_resolved(branch_resolved), .branch_miss(branch_miss),
        .fu_busy(fu_busy),
        .issue(issue), .freeze(freeze), .jump(jump), .halt(halt)
    );

    fu_status_table fust_i (
        .CLK(CLK), .nRST(nRST),
        .issue(issue), .fu_ex(fu_ex), .wb(wb), .branch_miss(branch_miss),
        .fust(fust), .fu_busy(fu_busy)
    );

endmodule

// ==== verilog/fu_status_table.sv ====
`include "dispatch_macros.svh"

module fu_status_table
    import dispatch_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,
    input  issue_t                          issue,
    input  logic [`NUM_FU-1:0]              fu_ex,
    input  wb_t                             wb,
    input  logic                            branch_miss,
    output fust_entry_t [`NUM_FU-1:0]       fust,
    output logic [`NUM_FU-1:0]              fu_busy
);

    // which tag slots hold matrix producers
    localparam logic [`NUM_FU-1:0] T1_MAT = `NUM_FU'(1) << FU_GEMM;
    localparam logic [`NUM_FU-1:0] T2_MAT = T1_MAT | (`NUM_FU'(1) << FU_MLS);

    fust_entry_t [`NUM_FU-1:0] nxt;

    function automatic logic tag_hit(
        input logic              mat,
        input logic [`TAG_W-1:0] t,
        input wb_t               w
    );
        if (t == '0)
            return 1'b0;
        return mat ? (w.m_en && t == w.m_tag) : (w.s_en && t == w.s_tag);
    endfunction

    always_comb begin
        nxt = fust;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (fust[i].busy) begin
                if (tag_hit(T1_MAT[i], fust[i].t1, wb))
                    nxt[i].t1 = '0;
                if (tag_hit(T2_MAT[i], fust[i].t2, wb))
                    nxt[i].t2 = '0;
                // t3 only used by gemm
                if (tag_hit(1'b1, fust[i].t3, wb))
                    nxt[i].t3 = '0;
            end
            if (fu_ex[i])
                nxt[i].busy = 1'b0;
            if (branch_miss && fust[i].busy && fust[i].spec) begin
                nxt[i].busy = 1'b0;
                nxt[i].spec = 1'b0;
            end
            if (issue.en && int'(issue.fu) == i)
                nxt[i] = issue.entry;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            fust <= '0;
        else
            fust <= nxt;
    end

    always_comb begin
        for (int i = 0; i < `NUM_FU; i++)
            fu_busy[i] = fust[i].busy;
    end

    // hazard logic upstream must hold back a busy unit
    a_issue_free: assert property (@(posedge CLK) disable iff (!nRST)
        issue.en |-> !fu_busy[issue.fu])
        else $error("issue to busy unit %0d", issue.fu);

endmodule

// ==== verilog/instr_decoder.sv ====
`include "dispatch_macros.svh"

module instr_decoder
    import dispatch_pkg::*;
(
    input  instr_u instr,
    output ctrl_t  ctrl
);

    scalar_fmt_t        sf;
    matrix_fmt_t        mf;
    logic [`WORD_W-1:0] raw;
    logic [`IMM_W-1:0]  i_imm;
    logic [`IMM_W-1:0]  s_imm;
    logic [`IMM_W-1:0]  b_imm;
    logic [`IMM_W-1:0]  j_imm;
    logic [`IMM_W-1:0]  m_imm;

    assign sf  = instr.scalar;
    assign mf  = instr.matrix;
    assign raw = instr;

    // immediate formats of the scalar view
    assign i_imm = {{20{raw[31]}}, raw[31:20]};
    assign s_imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
    assign b_imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
    assign j_imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
    // matrix load/store offset sits in the ms1/ms2 slots
    assign m_imm = {{24{mf.ms1[3]}}, mf.ms1, mf.ms2};

    always_comb begin
        ctrl    = '0;
        ctrl.fu = FU_NONE;
        case (sf.opcode)
            OP_ALU: begin
                ctrl.fu      = FU_ALU;
                ctrl.s_write = 1'b1;
                ctrl.alu_op  = {sf.funct7[5], sf.funct3};
            end
            OP_ALUI: begin
                ctrl.fu      = FU_ALU;
                ctrl.s_write = 1'b1;
                ctrl.imm     = i_imm;
                ctrl.alu_op  = {1'b0, sf.funct3};
            end
            OP_LOAD: begin
                ctrl.fu      = FU_LDST;
                ctrl.s_write = 1'b1;
                ctrl.imm     = i_imm;
                ctrl.alu_op  = {1'b0, sf.funct3};
            end
            OP_STORE: begin
                ctrl.fu     = FU_LDST;
                ctrl.imm    = s_imm;
                ctrl.alu_op = {1'b1, sf.funct3};
            end
            OP_BRANCH: begin
                ctrl.fu        = FU_BRANCH;
                ctrl.is_branch = 1'b1;
                ctrl.imm       = b_imm;
                ctrl.alu_op    = {1'b0, sf.funct3};
            end
            OP_JAL: begin
                ctrl.fu      = FU_BRANCH;
                ctrl.is_jump = 1'b1;
                ctrl.s_write = 1'b1;
                ctrl.imm     = j_imm;
                ctrl.alu_op  = 4'b1000;
            end
            OP_MLOAD: begin
                ctrl.fu      = FU_MLS;
                ctrl.m_write = 1'b1;
                ctrl.imm     = m_imm;
            end
            OP_MSTORE: begin
                ctrl.fu     = FU_MLS;
                ctrl.imm    = m_imm;
                ctrl.alu_op = 4'b1000;
            end
            OP_GEMM: begin
                // accumulator index rides in imm
                ctrl.fu      = FU_GEMM;
                ctrl.m_write = 1'b1;
                ctrl.imm     = {{(`IMM_W - 4){1'b0}}, mf.ms3};
                ctrl.alu_op  = {1'b0, mf.low[2:0]};
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== verilog/reg_status_table.sv ====
`include "dispatch_macros.svh"

module reg_status_table #(
    parameter int REGS  = 32,
    parameter int IDX_W = 5
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          di_en,
    input  logic [IDX_W-1:0]              di_sel,
    input  logic [`TAG_W-1:0]             di_tag,
    input  logic                          di_spec,
    input  logic                          wb_en,
    input  logic [IDX_W-1:0]              wb_sel,
    input  logic                          flush,
    input  logic                          resolved,
    output logic [REGS-1:0]               busy,
    output logic [REGS-1:0][`TAG_W-1:0]   tag
);

    logic [REGS-1:0] spec;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            tag  <= '0;
            spec <= '0;
        end else begin
            for (int i = 0; i < REGS; i++) begin
                if (flush && spec[i]) begin
                    busy[i] <= 1'b0;
                    tag[i]  <= '0;
                    spec[i] <= 1'b0;
                end else if (resolved) begin
                    spec[i] <= 1'b0;
                end
            end
            if (wb_en) begin
                busy[wb_sel] <= 1'b0;
                tag[wb_sel]  <= '0;
                spec[wb_sel] <= 1'b0;
            end
            // WAW stall keeps a new producer off a busy register
            if (di_en) begin
                busy[di_sel] <= 1'b1;
                tag[di_sel]  <= di_tag;
                spec[di_sel] <= di_spec;
            end
        end
    end

    a_no_di_wb_clash: assert property (@(posedge CLK) disable iff (!nRST)
        !(di_en && wb_en && di_sel == wb_sel))
        else $error("dispatch and writeback hit register %0d together", di_sel);

endmodule
